// File: gnn_edge_top.f
hdl/gnn_pkg.sv
hdl/edge_pe.sv
hdl/edge_dispatch.sv
hdl/wb_arbiter.sv
hdl/gnn_edge_top.sv
verification/gnn_edge_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the run from its log
verilator --binary --timing --assert --top-module gnn_edge_tb \
    -f gnn_edge_top.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vgnn_edge_tb > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0

// File: verification/gnn_edge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gnn_edge_tb;

    // six short tests, none longer than about 60 cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic                 clk = 1'b0;
    logic                 rst_n;
    gnn_pkg::edge_pkt_t   edge_in;
    logic                 stream_end;
    logic                 busy;
    logic                 result_valid;
    gnn_pkg::wb_pkt_t     result;
    logic                 task_complete;

    gnn_pkg::wb_pkt_t     exp_q[$];     // expected results searched by node id
    int                   rv_cycles[$]; // cycle of every result strobe
    int                   cycles;       // counted at each falling edge
    int                   eos_cycle;    // cycle in which the last eos was presented
    int                   tc_rise_cycle;
    logic                 tc_prev;
    logic                 busy_watch;   // busy must stay low while set
    logic [31:0]          lfsr_state;

    gnn_edge_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .edge_in       (edge_in),
        .stream_end    (stream_end),
        .busy          (busy),
        .result_valid  (result_valid),
        .result        (result),
        .task_complete (task_complete)
    );

    always #5 clk = ~clk;   // 10 ns period

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic gnn_pkg::fv_t random_feature();
        gnn_pkg::fv_t v;
        v = '0;
        for (int b = 0; b < gnn_pkg::FV_W; b++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            v[b]       = lfsr_state[0];
        end
        return v;
    endfunction

    // match one result against the scoreboard and retire the entry
    task automatic check_result(input gnn_pkg::wb_pkt_t got);
        int idx;
        idx = -1;
        foreach (exp_q[i]) begin
            if (exp_q[i].node_id == got.node_id) begin
                idx = i;
            end
        end
        assert (idx >= 0)
            else stop_on_error($sformatf("result for node id %h that was never sent",
                                         got.node_id));
        assert (got.edge_cnt == exp_q[idx].edge_cnt)
            else stop_on_error($sformatf("mismatch result.edge_cnt: got %h expected %h",
                                         got.edge_cnt, exp_q[idx].edge_cnt));
        for (int l = 0; l < gnn_pkg::NUM_LANES; l++) begin
            assert (got.sum[l] == exp_q[idx].sum[l])
                else stop_on_error($sformatf("mismatch result.sum[%0d]: got %h expected %h",
                                             l, got.sum[l], exp_q[idx].sum[l]));
        end
        exp_q.delete(idx);
    endtask

    // outputs sampled mid-cycle where they have settled
    always @(negedge clk) begin
        cycles = cycles + 1;
        assert (cycles <= TIMEOUT_CYCLES)
            else stop_on_error("timeout, the run did not finish within the cycle limit");
        if (result_valid) begin
            check_result(result);
            rv_cycles.push_back(cycles);
        end
        if (busy_watch) begin
            assert (!busy)
                else stop_on_error("busy went high while results were still draining");
        end
        if (task_complete && !tc_prev) begin
            tc_rise_cycle = cycles;
            assert (exp_q.size() == 0 && !result_valid)
                else stop_on_error("task_complete rose with results still outstanding");
        end
        tc_prev = task_complete;
    end

    // drives one node stream and builds its expected sums by saturating adds
    task automatic send_stream(input gnn_pkg::node_id_t node, input int n_edges,
                               input bit all_max);
        int                 lane_sum [gnn_pkg::NUM_LANES];
        int                 n_cnt;
        gnn_pkg::edge_pkt_t pkt;
        gnn_pkg::wb_pkt_t   exp;
        n_cnt = 0;
        foreach (lane_sum[l]) begin
            lane_sum[l] = 0;
        end
        for (int e = 0; e < n_edges; e++) begin
            pkt         = '0;
            pkt.valid   = 1'b1;
            pkt.sos     = (e == 0);
            pkt.eos     = (e == n_edges - 1);
            pkt.node_id = node;
            for (int l = 0; l < gnn_pkg::NUM_LANES; l++) begin
                pkt.fv[l]   = all_max ? 8'hff : random_feature();
                lane_sum[l] = lane_sum[l] + int'(pkt.fv[l]);
                if (lane_sum[l] > 4095) begin
                    lane_sum[l] = 4095;
                end
            end
            if (n_cnt < 255) begin
                n_cnt = n_cnt + 1;
            end
            @(posedge clk);
            #1;
            if (pkt.sos) begin
                while (busy) begin   // back-pressure only matters before an sos
                    edge_in.valid = 1'b0;
                    @(posedge clk);
                    #1;
                end
            end
            edge_in = pkt;
            if (pkt.eos) begin
                eos_cycle = cycles + 1;   // falling edge of this cycle bumps the count
            end
        end
        exp.node_id  = node;
        exp.edge_cnt = gnn_pkg::edge_cnt_t'(n_cnt);
        for (int l = 0; l < gnn_pkg::NUM_LANES; l++) begin
            exp.sum[l] = gnn_pkg::acc_t'(lane_sum[l]);
        end
        exp_q.push_back(exp);
    endtask

    task automatic idle_bus();
        @(posedge clk);
        #1;
        edge_in = '0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_reset_state();
        assert (!busy && !result_valid && !task_complete)
            else stop_on_error("an output was not low right after reset");
        @(negedge clk);
        assert (!busy && !result_valid && !task_complete)
            else stop_on_error("an output left its reset value with no input");
    endtask

    task automatic single_stream_test();
        rv_cycles.delete();
        send_stream(8'h10, 5, 1'b0);
        idle_bus();
        wait_drained();
        assert (rv_cycles.size() == 1)
            else stop_on_error("expected exactly one result strobe for a single stream");
        assert (rv_cycles[0] - eos_cycle == 2)
            else stop_on_error($sformatf("mismatch result_valid latency: got %h expected %h",
                                         rv_cycles[0] - eos_cycle, 2));
    endtask

    task automatic saturation_test();
        send_stream(8'h20, 20, 1'b1);   // 20 x 255 runs past 4095
        idle_bus();
        wait_drained();
    endtask

    // each result drains two cycles after its eos, so with one open stream
    // at most two PEs are taken at once and busy never rises
    task automatic back_to_back_test();
        rv_cycles.delete();
        busy_watch = 1'b1;
        send_stream(8'h30, 3, 1'b0);
        send_stream(8'h31, 2, 1'b0);
        send_stream(8'h32, 4, 1'b0);
        send_stream(8'h33, 3, 1'b0);
        idle_bus();
        wait_drained();
        busy_watch = 1'b0;
        assert (rv_cycles.size() == 4)
            else stop_on_error("four streams did not give four result strobes");
    endtask

    task automatic round_robin_drain_test();
        rv_cycles.delete();
        for (int n = 0; n < 4; n++) begin
            send_stream(gnn_pkg::node_id_t'(8'h40 + n), 1, 1'b0);   // sos and eos together
        end
        idle_bus();
        wait_drained();
        assert (rv_cycles.size() == 4)
            else stop_on_error("single-edge streams did not give four result strobes");
        assert (rv_cycles[3] - rv_cycles[0] == 3)
            else stop_on_error("results of consecutive eos edges were not one per cycle");
    endtask

    task automatic completion_test();
        rv_cycles.delete();
        send_stream(8'h50, 2, 1'b0);
        send_stream(8'h51, 1, 1'b0);
        send_stream(8'h52, 3, 1'b0);
        @(posedge clk);
        #1;
        edge_in    = '0;
        stream_end = 1'b1;
        @(posedge clk);
        #1;
        stream_end = 1'b0;
        while (!task_complete) begin
            @(negedge clk);
        end
        #1;   // monitor has logged the rise by now
        assert (rv_cycles.size() == 3 && rv_cycles[2] < tc_rise_cycle)
            else stop_on_error("task_complete rose before the last result strobe");
        repeat (3) @(posedge clk);
        #1;
        assert (task_complete)
            else stop_on_error("task_complete dropped with no new stream");
        send_stream(8'h53, 2, 1'b0);   // sos already taken when this returns
        assert (!task_complete)
            else stop_on_error("task_complete stayed high after a new sos");
        idle_bus();
        wait_drained();
    endtask

    initial begin
        rst_n         = 1'b0;
        edge_in       = '0;
        stream_end    = 1'b0;
        cycles        = 0;
        eos_cycle     = 0;
        tc_rise_cycle = 0;
        tc_prev       = 1'b0;
        busy_watch    = 1'b0;
        lfsr_state    = 32'he081;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_reset_state();
        single_stream_test();
        saturation_test();
        back_to_back_test();
        round_robin_drain_test();
        completion_test();
        if (exp_q.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_error("results still outstanding at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: hdl/gnn_edge_top.sv
`timescale 1ns/100ps
`default_nettype none

module gnn_edge_top (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire gnn_pkg::edge_pkt_t edge_in,
    input  wire                     stream_end,
    output logic                    busy,
    output logic                    result_valid,
    output gnn_pkg::wb_pkt_t        result,
    output logic                    task_complete
);

    wire gnn_pkg::edge_pkt_t [gnn_pkg::NUM_EDGE_PE-1:0] pe_edge;   // routed edges
    wire gnn_pkg::wb_pkt_t   [gnn_pkg::NUM_EDGE_PE-1:0] wb_data;   // held results
    wire gnn_pkg::pe_mask_t  pe_idle;
    wire gnn_pkg::pe_mask_t  wb_req;
    wire gnn_pkg::pe_mask_t  wb_grant;
    wire                     wb_pending;                          // any result not yet drained

    assign wb_pending = |wb_req;

    edge_dispatch edge_dispatch_u (
        .clk           (clk),
        .rst_n         (rst_n),
        .edge_in       (edge_in),
        .stream_end    (stream_end),
        .pe_idle       (pe_idle),
        .wb_pending    (wb_pending),
        .pe_edge       (pe_edge),
        .busy          (busy),
        .task_complete (task_complete)
    );

    // identical edge PEs, one per stream slot
    for (genvar i = 0; i < gnn_pkg::NUM_EDGE_PE; i++) begin : edge_pe_g
        edge_pe edge_pe_u (
            .clk      (clk),
            .rst_n    (rst_n),
            .edge_in  (pe_edge[i]),
            .wb_grant (wb_grant[i]),
            .idle     (pe_idle[i]),
            .wb_req   (wb_req[i]),
            .wb_data  (wb_data[i])
        );
    end

    wb_arbiter wb_arbiter_u (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_data      (wb_data),
        .wb_grant     (wb_grant),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: hdl/wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter (
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire gnn_pkg::pe_mask_t                      wb_req,
    input  wire gnn_pkg::wb_pkt_t [gnn_pkg::NUM_EDGE_PE-1:0] wb_data,
    output gnn_pkg::pe_mask_t                           wb_grant,
    output logic                                        result_valid,
    output gnn_pkg::wb_pkt_t                            result
);

    gnn_pkg::pe_idx_t ptr;        // highest priority this cycle
    gnn_pkg::pe_idx_t gnt_idx;    // winner of the rotating search
    logic             any_req;

    assign any_req = |wb_req;

    // nearest requester at or above ptr wins with wrap
    // index math wraps since the PE count is a power of two
    always_comb begin
        gnt_idx = ptr;
        for (int i = gnn_pkg::NUM_EDGE_PE - 1; i >= 0; i--) begin
            if (wb_req[ptr + gnn_pkg::pe_idx_t'(i)]) begin
                gnt_idx = ptr + gnn_pkg::pe_idx_t'(i);
            end
        end
    end

    always_comb begin
        wb_grant = '0;
        if (any_req) begin
            wb_grant[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= any_req;          // strobe one cycle after grant
            if (any_req) begin
                ptr <= gnt_idx + 1'b1;        // winner drops to lowest priority
            end
        end
    end

    // payload is qualified by result_valid
    always_ff @(posedge clk) begin
        if (any_req) begin
            result <= wb_data[gnt_idx];
        end
    end

    // every request is served within one turn of the pointer
    for (genvar i = 0; i < gnn_pkg::NUM_EDGE_PE; i++) begin : wait_bound_g
        gnn_pkg::pe_idx_t wait_cnt;   // cycles this request has gone unserved

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wait_cnt <= '0;
            end else if (wb_req[i] && !wb_grant[i]) begin
                wait_cnt <= wait_cnt + 1'b1;
            end else begin
                wait_cnt <= '0;
            end
        end

        req_starved_a: assert property (@(posedge clk) disable iff (!rst_n)
            wb_req[i] && !wb_grant[i]
            |-> wait_cnt != gnn_pkg::pe_idx_t'(gnn_pkg::NUM_EDGE_PE - 1))
            else $error("wb_arbiter: request left waiting for a full round");
    end

endmodule

`default_nettype wire

// File: hdl/edge_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module edge_dispatch (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire gnn_pkg::edge_pkt_t                       edge_in,
    input  wire                                           stream_end,
    input  wire gnn_pkg::pe_mask_t                        pe_idle,
    input  wire                                           wb_pending,
    output gnn_pkg::edge_pkt_t [gnn_pkg::NUM_EDGE_PE-1:0] pe_edge,
    output logic                                          busy,
    output logic                                          task_complete
);

    gnn_pkg::pe_idx_t  cur_pe;       // owner of the open stream
    gnn_pkg::pe_idx_t  first_idle;   // lowest idle PE this cycle
    gnn_pkg::pe_idx_t  sel_pe;       // where the current packet goes
    gnn_pkg::pe_mask_t bind_mask;    // PE taken by an sos this cycle
    logic              stream_open;
    logic              end_seen;     // source has signalled end of input
    logic              is_sos;
    logic              drained;      // nothing left anywhere in the array

    assign is_sos = edge_in.valid && edge_in.sos;

    // priority search, lowest index wins
    always_comb begin
        first_idle = '0;
        for (int i = gnn_pkg::NUM_EDGE_PE - 1; i >= 0; i--) begin
            if (pe_idle[i]) begin
                first_idle = gnn_pkg::pe_idx_t'(i);
            end
        end
    end

    assign sel_pe = is_sos ? first_idle : cur_pe;

    always_comb begin
        bind_mask = '0;
        if (is_sos) begin
            bind_mask[first_idle] = 1'b1;
        end
    end

    // payload fans out to all PEs, only the selected one sees valid
    always_comb begin
        for (int i = 0; i < gnn_pkg::NUM_EDGE_PE; i++) begin
            pe_edge[i]       = edge_in;
            pe_edge[i].valid = edge_in.valid && (is_sos || stream_open)
                               && (sel_pe == gnn_pkg::pe_idx_t'(i));
        end
    end

    assign drained = (&pe_idle) && !wb_pending && !stream_open;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_pe        <= '0;
            stream_open   <= 1'b0;
            busy          <= 1'b0;
            end_seen      <= 1'b0;
            task_complete <= 1'b0;
        end else begin
            // pe_idle lags a bind by one cycle, so mask the PE just taken
            busy <= ~|(pe_idle & ~bind_mask);

            if (is_sos) begin
                cur_pe      <= first_idle;
                stream_open <= !edge_in.eos;   // single-edge stream closes at once
            end else if (edge_in.valid && edge_in.eos) begin
                stream_open <= 1'b0;
            end

            // completion tracking, a new sos starts a fresh task
            if (is_sos) begin
                end_seen      <= 1'b0;
                task_complete <= 1'b0;
            end else begin
                if (stream_end) begin
                    end_seen <= 1'b1;
                end
                if ((end_seen || stream_end) && drained) begin
                    task_complete <= 1'b1;     // holds until next sos
                end
            end
        end
    end

    // source must respect back-pressure before opening a stream
    sos_while_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
        is_sos |-> !busy)
        else $error("edge_dispatch: sos presented while busy");

    // continuation edges need a stream bound to some PE
    edge_without_stream_a: assert property (@(posedge clk) disable iff (!rst_n)
        edge_in.valid && !edge_in.sos |-> stream_open)
        else $error("edge_dispatch: edge outside an open stream");

endmodule

`default_nettype wire

// File: hdl/edge_pe.sv
`timescale 1ns/100ps
`default_nettype none

module edge_pe (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire gnn_pkg::edge_pkt_t edge_in,
    input  wire                     wb_grant,
    output logic                    idle,
    output logic                    wb_req,
    output gnn_pkg::wb_pkt_t        wb_data
);

    gnn_pkg::pe_state_t                   state;
    gnn_pkg::acc_t [gnn_pkg::NUM_LANES-1:0] acc;   // per-lane running sums
    gnn_pkg::edge_cnt_t                   cnt;
    gnn_pkg::node_id_t                    node_id;
    logic                                 start;   // sos accepted
    logic                                 more;    // follow-on edge accepted

    // add one feature to a lane, clamp at the ceiling
    function automatic gnn_pkg::acc_t sat_add(input gnn_pkg::acc_t a, input gnn_pkg::fv_t b);
        logic [gnn_pkg::ACC_W:0] s;
        s = {1'b0, a} + (gnn_pkg::ACC_W + 1)'(b);
        return s[gnn_pkg::ACC_W] ? gnn_pkg::ACC_MAX : s[gnn_pkg::ACC_W-1:0];
    endfunction

    assign start = (state == gnn_pkg::idle) && edge_in.valid && edge_in.sos;
    assign more  = (state == gnn_pkg::accum) && edge_in.valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= gnn_pkg::idle;
        end else begin
            case (state)
                gnn_pkg::idle: begin
                    if (start) begin
                        state <= edge_in.eos ? gnn_pkg::wb_wait : gnn_pkg::accum;
                    end
                end
                gnn_pkg::accum: begin
                    if (edge_in.valid && edge_in.eos) begin
                        state <= gnn_pkg::wb_wait;
                    end
                end
                gnn_pkg::wb_wait: begin
                    if (wb_grant) begin
                        state <= gnn_pkg::idle;   // result taken by arbiter
                    end
                end
                default: state <= gnn_pkg::idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            for (int l = 0; l < gnn_pkg::NUM_LANES; l++) begin
                acc[l] <= gnn_pkg::acc_t'(edge_in.fv[l]);
            end
            cnt     <= gnn_pkg::edge_cnt_t'(1);
            node_id <= edge_in.node_id;
        end else if (more) begin
            for (int l = 0; l < gnn_pkg::NUM_LANES; l++) begin
                acc[l] <= sat_add(acc[l], edge_in.fv[l]);
            end
            if (cnt != gnn_pkg::CNT_MAX) begin
                cnt <= cnt + 1'b1;            // count sticks at 255
            end
            node_id <= edge_in.node_id;       // eos edge leaves the final id
        end
    end

    assign idle   = (state == gnn_pkg::idle);
    assign wb_req = (state == gnn_pkg::wb_wait);   // high from the cycle after eos

    always_comb begin
        wb_data.node_id  = node_id;
        wb_data.edge_cnt = cnt;
        wb_data.sum      = acc;
    end

    // arbiter only grants a PE that is asking
    grant_without_req_a: assert property (@(posedge clk) disable iff (!rst_n)
        wb_grant |-> wb_req)
        else $error("edge_pe: grant seen with no request");

endmodule

`default_nettype wire

// File: hdl/gnn_pkg.sv
`default_nettype none

package gnn_pkg;

    // array and datapath sizes
    localparam int NUM_EDGE_PE = 4;                   // 2 and 8 work too
    localparam int NUM_LANES   = 4;                   // feature lanes per packet
    localparam int FV_W        = 8;
    localparam int ACC_W       = 12;                  // lane sum, saturates at 4095
    localparam int NODE_ID_W   = 8;
    localparam int CNT_W       = 8;
    localparam int PE_IDX_W    = $clog2(NUM_EDGE_PE);

    typedef logic [FV_W-1:0]        fv_t;
    typedef logic [ACC_W-1:0]       acc_t;
    typedef logic [NODE_ID_W-1:0]   node_id_t;
    typedef logic [CNT_W-1:0]       edge_cnt_t;
    typedef logic [PE_IDX_W-1:0]    pe_idx_t;
    typedef logic [NUM_EDGE_PE-1:0] pe_mask_t;        // one bit per edge PE

    // saturation ceilings
    localparam acc_t      ACC_MAX = '1;
    localparam edge_cnt_t CNT_MAX = '1;

    // one edge of a node stream, 43 bits
    typedef struct packed {
        logic                  valid;   // one-cycle strobe
        logic                  sos;     // first edge of the node
        logic                  eos;     // last edge of the node
        node_id_t              node_id;
        fv_t [NUM_LANES-1:0]   fv;
    } edge_pkt_t;

    // finished aggregate of one node, 64 bits
    typedef struct packed {
        node_id_t              node_id;
        edge_cnt_t             edge_cnt;
        acc_t [NUM_LANES-1:0]  sum;
    } wb_pkt_t;

    // edge PE FSM
    typedef enum logic [1:0] {
        idle,       // free for a new stream
        accum,      // stream open
        wb_wait     // result held until granted
    } pe_state_t;

endpackage

`default_nettype wire
